// ==== core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and storage sizes
`define CORE_WORD_WIDTH      32
`define CORE_PROG_DEPTH      64
`define CORE_PC_WIDTH        6
`define CORE_STACK_DEPTH     8
`define CORE_DEPTH_WIDTH     4

// Opcodes live in the high nibble of each instruction byte
`define CORE_OP_HALT         4'h0
`define CORE_OP_PUSHI        4'h1
`define CORE_OP_ADD          4'h2
`define CORE_OP_SUB          4'h3
`define CORE_OP_AND          4'h4
`define CORE_OP_XOR          4'h5
`define CORE_OP_DUP          4'h6
`define CORE_OP_DROP         4'h7
`define CORE_OP_LOOP         4'h8
`define CORE_OP_INDEX        4'h9

// APB register map, byte addresses
`define CORE_APB_ADDR_WIDTH  12
`define CORE_REG_CTRL        12'h000
`define CORE_REG_STATUS      12'h004
`define CORE_REG_TOP         12'h008
`define CORE_REG_DEPTH       12'h00C
`define CORE_PROG_BASE       12'h100

`endif

// ==== core_pkg.sv ====
`default_nettype none

`include "core_consts.svh"

package core_pkg;

  typedef logic [`CORE_WORD_WIDTH-1:0]  word_t;
  typedef logic [`CORE_PC_WIDTH-1:0]    pc_t;
  typedef logic [`CORE_DEPTH_WIDTH-1:0] depth_t;
  typedef logic [7:0]                   instr_t;

  // Fault codes as reported in STATUS bits 6:4
  typedef enum logic [2:0] {
    F_NONE      = 3'd0,
    F_OVERFLOW  = 3'd1,
    F_UNDERFLOW = 3'd2,
    F_ILLEGAL   = 3'd3,
    F_LOOP_NEST = 3'd4
  } fault_t;

  typedef enum logic [1:0] {IDLE, RUN, DONE, FAULTED} run_state_t;

  // Order matches the opcode offset from ADD
  typedef enum logic [1:0] {ADD, SUB, AND, XOR} alu_op_t;

endpackage

`default_nettype wire

// ==== apb_host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module apb_host_regs (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            psel,
  input  wire logic                            penable,
  input  wire logic                            pwrite,
  input  wire logic [`CORE_APB_ADDR_WIDTH-1:0] paddr,
  input  wire core_pkg::word_t                 pwdata,
  output core_pkg::word_t                      prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  input  wire core_pkg::pc_t                   prog_addr,
  output core_pkg::instr_t                     instr,
  input  wire logic                            busy,
  input  wire logic                            done,
  input  wire core_pkg::word_t                 top,
  input  wire core_pkg::depth_t                depth,
  input  wire core_pkg::fault_t                fault,
  output logic                                 start
);
  import core_pkg::*;

  instr_t prog_mem [`CORE_PROG_DEPTH];
  pc_t    prog_index;
  logic   access;
  logic   prog_hit;
  logic   ctrl_hit;
  logic   reg_hit;
  logic   busy_write;

  // Transfers are ignored while reset is held
  assign access = rst_n && psel && penable;

  // Program bytes sit on word boundaries from PROG_BASE upwards
  assign prog_index = paddr[`CORE_PC_WIDTH+1:2];
  assign prog_hit   = (paddr & ~`CORE_APB_ADDR_WIDTH'((`CORE_PROG_DEPTH - 1) << 2))
                      == `CORE_PROG_BASE;
  assign ctrl_hit   = paddr == `CORE_REG_CTRL;
  assign reg_hit    = ctrl_hit || paddr == `CORE_REG_STATUS ||
                      paddr == `CORE_REG_TOP || paddr == `CORE_REG_DEPTH;

  // The program and the run control are locked while the core is busy
  assign busy_write = pwrite && busy && (prog_hit || ctrl_hit);

  assign pready  = 1'b1;
  assign pslverr = access && (!(prog_hit || reg_hit) || busy_write);

  // Start goes out during the CTRL access phase so the run begins on the next cycle
  assign start = access && pwrite && ctrl_hit && !busy && pwdata[0];

  always_ff @(posedge clk) begin
    if (access && pwrite && prog_hit && !busy) begin
      prog_mem[prog_index] <= pwdata[7:0];
    end
  end

  assign instr = prog_mem[prog_addr];

  always_comb begin
    prdata = '0;
    if (prog_hit) begin
      prdata = word_t'(prog_mem[prog_index]);
    end else begin
      case (paddr)
        `CORE_REG_STATUS: prdata = word_t'({fault, 2'b00, done, busy});
        `CORE_REG_TOP:    prdata = (depth == '0) ? '0 : top;
        `CORE_REG_DEPTH:  prdata = word_t'(depth);
        default:          prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== core_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_sequencer (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              start,
  input  wire core_pkg::instr_t  instr,
  output core_pkg::pc_t          prog_addr,
  output logic                   busy,
  output logic                   done,
  output core_pkg::fault_t       fault,
  output logic                   stack_clear,
  output logic                   push,
  output logic                   pop,
  output logic                   replace,
  output core_pkg::word_t        push_value,
  output core_pkg::alu_op_t      alu_op,
  input  wire core_pkg::word_t   alu_out,
  input  wire core_pkg::word_t   top,
  input  wire core_pkg::word_t   index,
  input  wire core_pkg::depth_t  depth,
  input  wire core_pkg::fault_t  stack_fault,
  output logic                   loop_start,
  output logic [3:0]             loop_len,
  output core_pkg::word_t        loop_count,
  input  wire logic              loop_active,
  input  wire logic              loop_back,
  input  wire logic              loop_exit,
  input  wire core_pkg::pc_t     loop_target
);
  import core_pkg::*;

  run_state_t state;
  pc_t        pc;
  pc_t        pc_next;
  logic [3:0] opcode;
  logic [3:0] operand;
  logic [3:0] alu_sel;
  logic       is_halt;
  logic       loop_op;
  fault_t     seq_fault;
  fault_t     fault_now;

  assign opcode  = instr[7:4];
  assign operand = instr[3:0];

  assign alu_sel = opcode - `CORE_OP_ADD;
  assign alu_op  = alu_op_t'(alu_sel[1:0]);

  // Decode one instruction per cycle; a faulting instruction raises no strobe
  always_comb begin
    push       = 1'b0;
    pop        = 1'b0;
    replace    = 1'b0;
    push_value = '0;
    is_halt    = 1'b0;
    loop_op    = 1'b0;
    seq_fault  = F_NONE;
    if (state == RUN) begin
      case (opcode)
        `CORE_OP_HALT:  is_halt = 1'b1;
        `CORE_OP_PUSHI: begin
          push       = 1'b1;
          push_value = word_t'(operand);
        end
        `CORE_OP_ADD, `CORE_OP_SUB, `CORE_OP_AND, `CORE_OP_XOR: begin
          pop        = 1'b1;
          replace    = 1'b1;
          push_value = alu_out;
        end
        `CORE_OP_DUP: begin
          if (depth == '0) begin
            seq_fault = F_UNDERFLOW;
          end else begin
            push       = 1'b1;
            push_value = top;
          end
        end
        `CORE_OP_DROP:  pop = 1'b1;
        `CORE_OP_LOOP: begin
          if (operand == '0) begin
            seq_fault = F_ILLEGAL;
          end else if (loop_active) begin
            seq_fault = F_LOOP_NEST;
          end else begin
            pop     = 1'b1;
            loop_op = 1'b1;
          end
        end
        `CORE_OP_INDEX: begin
          push       = 1'b1;
          push_value = index;
        end
        default:        seq_fault = F_ILLEGAL;
      endcase
    end
  end

  assign fault_now  = (seq_fault != F_NONE) ? seq_fault : stack_fault;
  assign loop_start = loop_op && stack_fault == F_NONE;
  assign loop_len   = operand;
  assign loop_count = top;

  assign pc_next     = (loop_back || loop_exit) ? loop_target : pc_t'(pc + 1'b1);
  assign prog_addr   = pc;
  assign stack_clear = start;
  assign busy        = state == RUN;
  assign done        = state == DONE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      pc    <= '0;
      fault <= F_NONE;
    end else if (start) begin
      state <= RUN;
      pc    <= '0;
      fault <= F_NONE;
    end else if (state == RUN) begin
      // The first fault stops the run with pc left on the faulting instruction
      if (fault_now != F_NONE) begin
        fault <= fault_now;
        state <= FAULTED;
      end else if (is_halt) begin
        state <= DONE;
      end else begin
        pc <= pc_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== loop_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module loop_counter (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             clear,
  input  wire logic             loop_start,
  input  wire logic [3:0]       loop_len,
  input  wire core_pkg::word_t  loop_count,
  input  wire core_pkg::pc_t    pc,
  output logic                  loop_active,
  output logic                  loop_back,
  output logic                  loop_exit,
  output core_pkg::pc_t         loop_target,
  output core_pkg::word_t       index
);
  import core_pkg::*;

  pc_t   beginning;
  pc_t   ending;
  word_t total;
  word_t index_next;
  logic  at_end;

  assign index_next = index + 1'b1;
  assign at_end     = loop_active && pc == ending;

  // A zero count jumps straight past the body from the LOOP itself
  assign loop_exit   = (loop_start && loop_count == '0) || (at_end && index_next == total);
  assign loop_back   = at_end && index_next != total;
  assign loop_target = loop_back  ? beginning :
                       loop_start ? pc_t'(pc + loop_len + 1'b1) :
                                    pc_t'(ending + 1'b1);

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      loop_active <= 1'b0;
      index       <= '0;
    end else if (loop_start) begin
      loop_active <= loop_count != '0;
      index       <= '0;
    end else if (loop_back) begin
      index <= index_next;
    end else if (loop_exit) begin
      loop_active <= 1'b0;
    end
  end

  // Body bounds and iteration total of the active loop
  always_ff @(posedge clk) begin
    if (loop_start) begin
      beginning <= pc_t'(pc + 1'b1);
      ending    <= pc_t'(pc + loop_len);
      total     <= loop_count;
    end
  end

endmodule

`default_nettype wire

// ==== data_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module data_stack (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             clear,
  input  wire logic             push,
  input  wire logic             pop,
  input  wire logic             replace,
  input  wire core_pkg::word_t  push_value,
  output core_pkg::word_t       top,
  output core_pkg::word_t       second,
  output core_pkg::depth_t      depth,
  output core_pkg::fault_t      stack_fault
);
  import core_pkg::*;

  word_t  mem [`CORE_STACK_DEPTH];
  depth_t depth_next;
  logic   wr_en;
  logic [`CORE_DEPTH_WIDTH-2:0] wr_idx;
  logic [`CORE_DEPTH_WIDTH-2:0] top_idx;
  logic [`CORE_DEPTH_WIDTH-2:0] second_idx;

  // Entry 0 is the bottom; the top sits at depth - 1
  assign top_idx    = depth[`CORE_DEPTH_WIDTH-2:0] - 1'b1;
  assign second_idx = depth[`CORE_DEPTH_WIDTH-2:0] - 2'd2;
  assign top        = mem[top_idx];
  assign second     = mem[second_idx];

  // Moves the stack cannot take are refused and flagged
  always_comb begin
    stack_fault = F_NONE;
    wr_en       = 1'b0;
    wr_idx      = top_idx;
    depth_next  = depth;
    case ({push, pop, replace})
      3'b100: begin
        if (depth == `CORE_STACK_DEPTH) begin
          stack_fault = F_OVERFLOW;
        end else begin
          wr_en      = 1'b1;
          wr_idx     = depth[`CORE_DEPTH_WIDTH-2:0];
          depth_next = depth + 1'b1;
        end
      end
      3'b010: begin
        if (depth == '0) stack_fault = F_UNDERFLOW;
        else depth_next = depth - 1'b1;
      end
      // Pop two, push one: the result lands where the second entry was
      3'b011: begin
        if (depth < 2) begin
          stack_fault = F_UNDERFLOW;
        end else begin
          wr_en      = 1'b1;
          wr_idx     = second_idx;
          depth_next = depth - 1'b1;
        end
      end
      3'b001: begin
        if (depth == '0) stack_fault = F_UNDERFLOW;
        else wr_en = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) depth <= '0;
    else depth <= depth_next;
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_idx] <= push_value;
  end

endmodule

`default_nettype wire

// ==== stack_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module stack_alu (
  input  wire core_pkg::word_t    a,
  input  wire core_pkg::word_t    b,
  input  wire core_pkg::alu_op_t  op,
  output core_pkg::word_t         y
);
  import core_pkg::*;

  // Operand a is the second entry and b the top, so SUB gives second - top
  always_comb begin
    case (op)
      ADD:     y = a + b;
      SUB:     y = a - b;
      AND:     y = a & b;
      XOR:     y = a ^ b;
      default: y = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== stack_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module stack_core (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            psel,
  input  wire logic                            penable,
  input  wire logic                            pwrite,
  input  wire logic [`CORE_APB_ADDR_WIDTH-1:0] paddr,
  input  wire core_pkg::word_t                 pwdata,
  output core_pkg::word_t                      prdata,
  output logic                                 pready,
  output logic                                 pslverr
);
  import core_pkg::*;

  pc_t        prog_addr;
  instr_t     instr;
  logic       busy;
  logic       done;
  logic       start;
  fault_t     fault;
  fault_t     stack_fault;
  logic       stack_clear;
  logic       push;
  logic       pop;
  logic       replace;
  word_t      push_value;
  word_t      top;
  word_t      second;
  depth_t     depth;
  alu_op_t    alu_op;
  word_t      alu_out;
  logic       loop_start;
  logic [3:0] loop_len;
  word_t      loop_count;
  logic       loop_active;
  logic       loop_back;
  logic       loop_exit;
  pc_t        loop_target;
  word_t      index;

  apb_host_regs u_apb_host_regs (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .prog_addr, .instr, .busy, .done, .top, .depth, .fault, .start
  );

  core_sequencer u_core_sequencer (
    .clk, .rst_n, .start, .instr, .prog_addr, .busy, .done, .fault,
    .stack_clear, .push, .pop, .replace, .push_value, .alu_op, .alu_out,
    .top, .index, .depth, .stack_fault,
    .loop_start, .loop_len, .loop_count, .loop_active, .loop_back, .loop_exit, .loop_target
  );

  // The loop counter watches the pc of the instruction being executed
  loop_counter u_loop_counter (
    .clk, .rst_n, .clear(stack_clear), .loop_start, .loop_len, .loop_count,
    .pc(prog_addr), .loop_active, .loop_back, .loop_exit, .loop_target, .index
  );

  data_stack u_data_stack (
    .clk, .rst_n, .clear(stack_clear), .push, .pop, .replace, .push_value,
    .top, .second, .depth, .stack_fault
  );

  stack_alu u_stack_alu (
    .a(second), .b(top), .op(alu_op), .y(alu_out)
  );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // Free-running clock with an 8 ns period
  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

endmodule

`default_nettype wire

// ==== stack_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module stack_core_tb;
  import core_pkg::*;

  localparam int CLK_PERIOD_NS  = 8;
  localparam int NUM_PROGRAMS   = 20;
  localparam int PROGRAM_CYCLES = 300;
  localparam int BUSY_LIMIT     = 200;

  logic                            clk;
  logic                            rst_n;
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  logic [`CORE_APB_ADDR_WIDTH-1:0] paddr;
  logic [31:0]                     pwdata;
  logic [31:0]                     prdata;
  logic                            pready;
  logic                            pslverr;

  // Mirror of the DUT program memory that the model executes
  logic [7:0]  prog_img [`CORE_PROG_DEPTH];
  logic [31:0] lfsr_state  = 32'h3fde_8805;
  int          cycle_count = 0;

  tb_clock u_tb_clock (.clk);

  stack_core u_stack_core (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [`CORE_APB_ADDR_WIDTH-1:0] prog_byte_addr(input int n);
    return `CORE_PROG_BASE + `CORE_APB_ADDR_WIDTH'(n * 4);
  endfunction

  // Executes prog_img from pc 0 by the ISA rules and reports the final state
  function automatic void model_run(output logic [31:0] m_top, output logic [3:0] m_depth,
                                    output logic [2:0] m_fault, output logic m_done);
    logic [31:0] stk [8];
    int          d;
    int          steps;
    logic [5:0]  pc;
    logic [3:0]  op;
    logic [3:0]  arg;
    logic        running;
    logic        jumped;
    logic        active;
    logic [5:0]  lp_begin;
    logic [5:0]  lp_end;
    logic [31:0] lp_total;
    logic [31:0] lp_index;
    logic [31:0] a;
    logic [31:0] b;
    d        = 0;
    steps    = 0;
    pc       = 6'd0;
    running  = 1'b1;
    active   = 1'b0;
    lp_begin = 6'd0;
    lp_end   = 6'd0;
    lp_total = 32'd0;
    lp_index = 32'd0;
    m_fault  = F_NONE;
    m_done   = 1'b0;
    for (int i = 0; i < 8; i++) begin
      stk[i] = 32'd0;
    end
    while (running && steps < 1000) begin
      op     = prog_img[pc][7:4];
      arg    = prog_img[pc][3:0];
      jumped = 1'b0;
      steps++;
      case (op)
        `CORE_OP_HALT: begin
          m_done  = 1'b1;
          running = 1'b0;
        end
        `CORE_OP_PUSHI, `CORE_OP_DUP, `CORE_OP_INDEX: begin
          if (op == `CORE_OP_DUP && d == 0) begin
            m_fault = F_UNDERFLOW;
          end else if (d == 8) begin
            m_fault = F_OVERFLOW;
          end else begin
            case (op)
              `CORE_OP_PUSHI: stk[d] = 32'(arg);
              `CORE_OP_DUP:   stk[d] = stk[d-1];
              default:        stk[d] = lp_index;
            endcase
            d++;
          end
        end
        `CORE_OP_ADD, `CORE_OP_SUB, `CORE_OP_AND, `CORE_OP_XOR: begin
          if (d < 2) begin
            m_fault = F_UNDERFLOW;
          end else begin
            a = stk[d-2];
            b = stk[d-1];
            case (op)
              `CORE_OP_ADD: stk[d-2] = a + b;
              `CORE_OP_SUB: stk[d-2] = a - b;
              `CORE_OP_AND: stk[d-2] = a & b;
              default:      stk[d-2] = a ^ b;
            endcase
            d--;
          end
        end
        `CORE_OP_DROP: begin
          if (d == 0) begin
            m_fault = F_UNDERFLOW;
          end else begin
            d--;
          end
        end
        `CORE_OP_LOOP: begin
          if (arg == 4'd0) begin
            m_fault = F_ILLEGAL;
          end else if (active) begin
            m_fault = F_LOOP_NEST;
          end else if (d == 0) begin
            m_fault = F_UNDERFLOW;
          end else begin
            d--;
            if (stk[d] == 32'd0) begin
              // A zero count skips the whole body
              pc     = pc + 6'(arg) + 6'd1;
              jumped = 1'b1;
            end else begin
              active   = 1'b1;
              lp_begin = pc + 6'd1;
              lp_end   = pc + 6'(arg);
              lp_total = stk[d];
              lp_index = 32'd0;
            end
          end
        end
        default: m_fault = F_ILLEGAL;
      endcase
      if (m_fault != F_NONE) begin
        running = 1'b0;
      end
      if (running && !jumped) begin
        if (active && pc == lp_end) begin
          if (lp_index + 32'd1 != lp_total) begin
            lp_index = lp_index + 32'd1;
            pc       = lp_begin;
          end else begin
            active = 1'b0;
            pc     = lp_end + 6'd1;
          end
        end else begin
          pc = pc + 6'd1;
        end
      end
    end
    m_depth = 4'(d);
    if (d == 0) begin
      m_top = 32'd0;
    end else begin
      m_top = stk[d-1];
    end
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns: %s: read 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "mismatch");
    end
  endtask

  // One APB transfer with a setup phase and an access phase, then the bus is released
  task automatic apb_transfer(input logic write, input logic [`CORE_APB_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    check_value(32'(pready), 32'd1, "pready in the access phase");
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_checked(input logic [`CORE_APB_ADDR_WIDTH-1:0] addr,
                               input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata, err);
    check_value(32'(err), 32'd0, $sformatf("pslverr on write to 0x%03h", addr));
  endtask

  task automatic read_checked(input logic [`CORE_APB_ADDR_WIDTH-1:0] addr,
                              output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, 32'd0, data, err);
    check_value(32'(err), 32'd0, $sformatf("pslverr on read of 0x%03h", addr));
  endtask

  task automatic load_program(input int len);
    for (int i = 0; i < len; i++) begin
      write_checked(prog_byte_addr(i), 32'(prog_img[i]));
    end
  endtask

  task automatic start_run();
    write_checked(`CORE_REG_CTRL, 32'h1);
  endtask

  // Polls STATUS until busy falls or the run length limit passes
  task automatic wait_idle();
    int          t0;
    logic [31:0] status;
    t0     = cycle_count;
    status = 32'h1;
    while (status[0] && cycle_count - t0 <= BUSY_LIMIT) begin
      read_checked(`CORE_REG_STATUS, status);
    end
    if (status[0]) begin
      $display("The core stayed busy for more than %0d cycles", BUSY_LIMIT);
      $display("Test failed");
      $fatal(1, "busy timeout");
    end
  endtask

  task automatic compare_result(input string what);
    logic [31:0] m_top;
    logic [3:0]  m_depth;
    logic [2:0]  m_fault;
    logic        m_done;
    logic [31:0] value;
    model_run(m_top, m_depth, m_fault, m_done);
    read_checked(`CORE_REG_STATUS, value);
    check_value(value, {25'd0, m_fault, 2'b00, m_done, 1'b0}, {what, " STATUS"});
    read_checked(`CORE_REG_TOP, value);
    check_value(value, m_top, {what, " TOP"});
    read_checked(`CORE_REG_DEPTH, value);
    check_value(value, 32'(m_depth), {what, " DEPTH"});
  endtask

  task automatic run_program(input int len, input string what);
    load_program(len);
    start_run();
    wait_idle();
    compare_result(what);
  endtask

  task automatic check_fault(input logic [2:0] expected, input string what);
    logic [31:0] value;
    read_checked(`CORE_REG_STATUS, value);
    check_value(32'(value[6:4]), 32'(expected), {what, " fault code"});
  endtask

  // Random arithmetic program ended by HALT whose depth stays within 0 to 8
  task automatic build_arith(output int len);
    int         d;
    int         n;
    logic [3:0] op;
    d = 0;
    n = 6 + int'(take_bits(3));
    for (int i = 0; i < n; i++) begin
      case (3'(take_bits(3)))
        3'd1:    op = `CORE_OP_ADD;
        3'd2:    op = `CORE_OP_SUB;
        3'd3:    op = `CORE_OP_AND;
        3'd4:    op = `CORE_OP_XOR;
        3'd5:    op = `CORE_OP_DUP;
        3'd6:    op = `CORE_OP_DROP;
        default: op = `CORE_OP_PUSHI;
      endcase
      if (op >= `CORE_OP_ADD && op <= `CORE_OP_XOR && d < 2) begin
        op = `CORE_OP_PUSHI;
      end
      if (op == `CORE_OP_DUP && (d == 0 || d == 8)) begin
        op = (d == 0) ? `CORE_OP_PUSHI : `CORE_OP_DROP;
      end
      if (op == `CORE_OP_DROP && d == 0) begin
        op = `CORE_OP_PUSHI;
      end
      if (op == `CORE_OP_PUSHI && d == 8) begin
        op = `CORE_OP_ADD;
      end
      if (op == `CORE_OP_PUSHI || op == `CORE_OP_DUP) begin
        d++;
      end else begin
        d--;
      end
      prog_img[i] = {op, (op == `CORE_OP_PUSHI) ? 4'(take_bits(4)) : 4'h0};
    end
    prog_img[n] = {`CORE_OP_HALT, 4'h0};
    len = n + 1;
  endtask

  initial begin
    #(NUM_PROGRAMS * PROGRAM_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired after %0d ns before the tests finished",
             NUM_PROGRAMS * PROGRAM_CYCLES * CLK_PERIOD_NS);
    $display("Test failed");
    $fatal(1, "watchdog");
  end

  initial begin
    logic [31:0] value;
    logic [31:0] junk;
    logic        err;
    int          len;
    int          count;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    read_checked(`CORE_REG_STATUS, value);
    check_value(value, 32'd0, "STATUS after reset");
    read_checked(`CORE_REG_TOP, value);
    check_value(value, 32'd0, "TOP after reset");
    read_checked(`CORE_REG_DEPTH, value);
    check_value(value, 32'd0, "DEPTH after reset");
    apb_transfer(1'b0, 12'h010, 32'd0, value, err);
    check_value(32'(err), 32'd1, "pslverr on unmapped read");
    apb_transfer(1'b1, 12'h200, 32'd0, value, err);
    check_value(32'(err), 32'd1, "pslverr on unmapped write");

    // Address-dependent fill with random upper bytes that must not be stored
    for (int i = 0; i < `CORE_PROG_DEPTH; i++) begin
      prog_img[i] = 8'(i * 73 + 29);
      junk = take_bits(24);
      write_checked(prog_byte_addr(i), {junk[23:0], prog_img[i]});
    end
    for (int i = 0; i < `CORE_PROG_DEPTH; i++) begin
      read_checked(prog_byte_addr(i), value);
      check_value(value, 32'(prog_img[i]), $sformatf("program byte %0d", i));
    end

    for (int k = 0; k < 10; k++) begin
      build_arith(len);
      run_program(len, $sformatf("arithmetic program %0d", k));
    end

    // Each pass adds its loop index plus one to a random accumulator
    for (int k = 0; k < 3; k++) begin
      count = (k == 0) ? 0 : int'(take_bits(3)) % 6;
      prog_img[0] = {`CORE_OP_PUSHI, 4'(take_bits(4))};
      prog_img[1] = {`CORE_OP_PUSHI, 4'(count)};
      prog_img[2] = {`CORE_OP_LOOP, 4'd4};
      prog_img[3] = {`CORE_OP_PUSHI, 4'd1};
      prog_img[4] = {`CORE_OP_ADD, 4'd0};
      prog_img[5] = {`CORE_OP_INDEX, 4'd0};
      prog_img[6] = {`CORE_OP_ADD, 4'd0};
      prog_img[7] = {`CORE_OP_HALT, 4'd0};
      run_program(8, $sformatf("loop with count %0d", count));
    end

    // A 60-iteration loop keeps the core busy while the host tries to write
    prog_img[0] = {`CORE_OP_PUSHI, 4'd0};
    prog_img[1] = {`CORE_OP_PUSHI, 4'd15};
    prog_img[2] = {`CORE_OP_DUP, 4'd0};
    prog_img[3] = {`CORE_OP_ADD, 4'd0};
    prog_img[4] = {`CORE_OP_DUP, 4'd0};
    prog_img[5] = {`CORE_OP_ADD, 4'd0};
    prog_img[6] = {`CORE_OP_LOOP, 4'd2};
    prog_img[7] = {`CORE_OP_INDEX, 4'd0};
    prog_img[8] = {`CORE_OP_ADD, 4'd0};
    prog_img[9] = {`CORE_OP_HALT, 4'd0};
    load_program(10);
    start_run();
    apb_transfer(1'b1, prog_byte_addr(0), 32'd0, value, err);
    check_value(32'(err), 32'd1, "pslverr on program write while busy");
    apb_transfer(1'b1, `CORE_REG_CTRL, 32'h1, value, err);
    check_value(32'(err), 32'd1, "pslverr on CTRL write while busy");
    read_checked(`CORE_REG_STATUS, value);
    check_value(32'(value[0]), 32'd1, "busy during the long loop");
    wait_idle();
    compare_result("long loop");
    read_checked(prog_byte_addr(0), value);
    check_value(value, 32'(prog_img[0]), "program byte 0 after refused write");

    for (int k = 0; k < 9; k++) begin
      prog_img[k] = {`CORE_OP_PUSHI, 4'(k + 1)};
    end
    prog_img[9] = {`CORE_OP_HALT, 4'd0};
    run_program(10, "overflow");
    check_fault(F_OVERFLOW, "overflow");

    prog_img[0] = {`CORE_OP_PUSHI, 4'd3};
    prog_img[1] = {`CORE_OP_ADD, 4'd0};
    prog_img[2] = {`CORE_OP_HALT, 4'd0};
    run_program(3, "underflow");
    check_fault(F_UNDERFLOW, "underflow");

    prog_img[0] = {`CORE_OP_PUSHI, 4'd2};
    prog_img[1] = 8'hA5;
    prog_img[2] = {`CORE_OP_HALT, 4'd0};
    run_program(3, "illegal opcode");
    check_fault(F_ILLEGAL, "illegal opcode");

    prog_img[0] = {`CORE_OP_PUSHI, 4'd2};
    prog_img[1] = {`CORE_OP_LOOP, 4'd3};
    prog_img[2] = {`CORE_OP_PUSHI, 4'd1};
    prog_img[3] = {`CORE_OP_LOOP, 4'd1};
    prog_img[4] = {`CORE_OP_PUSHI, 4'd5};
    prog_img[5] = {`CORE_OP_HALT, 4'd0};
    run_program(6, "loop nest");
    check_fault(F_LOOP_NEST, "loop nest");

    // After the fault a restart with an empty program shows the cleared stack
    prog_img[0] = {`CORE_OP_HALT, 4'd0};
    run_program(1, "restart with HALT only");
    prog_img[0] = {`CORE_OP_PUSHI, 4'd4};
    prog_img[1] = {`CORE_OP_PUSHI, 4'd9};
    prog_img[2] = {`CORE_OP_SUB, 4'd0};
    prog_img[3] = {`CORE_OP_HALT, 4'd0};
    run_program(4, "restart with SUB");

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
core_pkg.sv
apb_host_regs.sv
core_sequencer.sv
loop_counter.sv
data_stack.sv
stack_alu.sv
stack_core.sv
tb_clock.sv
stack_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the stack core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module stack_core_tb -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vstack_core_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi
exit 0
